// ==== source/dphy_consts.svh ====
`ifndef DPHY_CONSTS_SVH
`define DPHY_CONSTS_SVH

// the HS sync byte that follows the leader, sent LSB first on each lane.
`define DPHY_SYNC_BYTE    8'hB8

// lane count used when the parent does not override DATA_LANES.
`define DPHY_DATA_LANES   2

// Entries per lane in the deskew buffer. Covers two byte clocks of lane skew
// plus one more from the bit offset and one from the release register.
`define DPHY_SKEW_DEPTH   4

// cycles after pkt_done_i by which no word is left in the pipeline.
`define DPHY_FLUSH_CYCLES 3

`endif

// ==== source/dphy_lane_pkg.sv ====
package dphy_lane_pkg;

  // one deserialized byte of a data lane, bit 0 was received first.
  typedef logic [7:0] lane_byte_t;

  // A lane hunts for the sync byte after reset and after every packet.
  // Once the sync is seen the bit offset is frozen until the next re-arm.
  typedef enum logic {
    ALIGN_HUNT   = 1'b0,
    ALIGN_LOCKED = 1'b1
  } align_state_t;

endpackage

// ==== source/dphy_word_pkg.sv ====
package dphy_word_pkg;

  // packed payload word as it leaves the receiver.
  typedef logic [31:0] word_t;

  // byte position inside word_t, 0 is bits 7:0.
  typedef logic [1:0] byte_idx_t;

endpackage

// ==== source/dphy_lane_if.sv ====
`timescale 1ns/1ns
`include "dphy_consts.svh"

interface dphy_lane_if #(
  parameter int DATA_LANES = `DPHY_DATA_LANES
);

  dphy_lane_pkg::lane_byte_t byte_data  [DATA_LANES];
  logic                      byte_valid [DATA_LANES];
  logic                      locked     [DATA_LANES];
  logic                      rearm;      // one pulse per packet end.

  modport align (
    output byte_data,
    output byte_valid,
    output locked,
    input  rearm
  );

  modport deskew (
    input  byte_data,
    input  byte_valid,
    input  locked,
    output rearm
  );

endinterface

// ==== source/dphy_byte_align.sv ====
`timescale 1ns/1ns
`include "dphy_consts.svh"

module dphy_byte_align #(
  parameter int LANE = 0
)(
  input                            byte_clk_i,
  input                            rst_i,
  input                            enable_i,
  input dphy_lane_pkg::lane_byte_t unaligned_byte_i,
  dphy_lane_if.align               lane_o
);

dphy_lane_pkg::lane_byte_t   in_q;
dphy_lane_pkg::lane_byte_t   prev_q;
logic [15:0]                 window;
logic                        found;
logic [2:0]                  found_off;
logic [2:0]                  off_q;
dphy_lane_pkg::align_state_t state_q;
dphy_lane_pkg::lane_byte_t   data_q;
logic                        valid_q;

// bits arrive LSB first, so the older byte fills the low half.
assign window = { in_q, prev_q };

always_comb
begin
  found     = 1'b0;
  found_off = '0;
  // Scan from the top so that the lowest matching offset is kept.
  for( int k = 7; k >= 0; k-- )
  begin
    if( window[k +: 8] == `DPHY_SYNC_BYTE )
    begin
      found     = 1'b1;
      found_off = 3'(k);
    end
  end
end

always_ff @( posedge byte_clk_i )
begin
  in_q   <= unaligned_byte_i;
  prev_q <= in_q;
end

always_ff @( posedge byte_clk_i )
begin
  if( rst_i )
  begin
    state_q <= dphy_lane_pkg::ALIGN_HUNT;
    valid_q <= 1'b0;
  end
  else if( !enable_i || lane_o.rearm )
  begin
    state_q <= dphy_lane_pkg::ALIGN_HUNT;
    valid_q <= 1'b0;
  end
  else if( state_q == dphy_lane_pkg::ALIGN_HUNT )
  begin
    valid_q <= 1'b0; // the sync byte itself is not passed on.
    if( found )
      state_q <= dphy_lane_pkg::ALIGN_LOCKED;
  end
  else
  begin
    valid_q <= 1'b1;
  end
end

always_ff @( posedge byte_clk_i )
begin
  if( state_q == dphy_lane_pkg::ALIGN_HUNT && found )
    off_q <= found_off;
  data_q <= window[off_q +: 8];
end

assign lane_o.byte_data[LANE]  = data_q;
assign lane_o.byte_valid[LANE] = valid_q;
assign lane_o.locked[LANE]     = ( state_q == dphy_lane_pkg::ALIGN_LOCKED );

// a valid byte needs a lock that was already in place one cycle earlier.
valid_after_lock: assert property (
  @( posedge byte_clk_i ) disable iff ( rst_i )
  lane_o.byte_valid[LANE] |-> lane_o.locked[LANE] && $past( lane_o.locked[LANE] )
);

endmodule

// ==== source/dphy_word_align.sv ====
`timescale 1ns/1ns
`include "dphy_consts.svh"

module dphy_word_align #(
  parameter int DATA_LANES = `DPHY_DATA_LANES
)(
  input                                              byte_clk_i,
  input                                              rst_i,
  input                                              pkt_done_i,
  dphy_lane_if.deskew                                lanes_i,
  output dphy_lane_pkg::lane_byte_t [DATA_LANES-1:0] lane_word_o,
  output                                             word_valid_o,
  output                                             flush_o
);

localparam int DEPTH = `DPHY_SKEW_DEPTH;
localparam int PTR_W = $clog2( DEPTH );
localparam int CNT_W = $clog2( DEPTH + 1 );

logic [DATA_LANES-1:0]                      not_empty;
logic [DATA_LANES-1:0]                      full;
dphy_lane_pkg::lane_byte_t                  head [DATA_LANES];
logic                                       pop;
logic                                       rearm_q;
logic                                       flush_q;
logic                                       word_valid_q;
dphy_lane_pkg::lane_byte_t [DATA_LANES-1:0] lane_word_q;

// a lane word leaves only when every lane has caught up.
assign pop = &not_empty;

for( genvar l = 0; l < DATA_LANES; l++ )
begin : lane
  dphy_lane_pkg::lane_byte_t mem_q [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          count_q;
  logic                      wr;

  // bytes still in flight from the old packet are dropped during re-arm.
  assign wr           = lanes_i.byte_valid[l] && lanes_i.locked[l] && !rearm_q;
  assign not_empty[l] = ( count_q != '0 );
  assign full[l]      = ( count_q == CNT_W'(DEPTH) );
  assign head[l]      = mem_q[rd_ptr_q];

  always_ff @( posedge byte_clk_i )
  begin
    if( rst_i || pkt_done_i )
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if( wr )
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if( pop )
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if( wr && !pop )
        count_q <= count_q + 1'b1;
      else if( pop && !wr )
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @( posedge byte_clk_i )
  begin
    if( wr )
      mem_q[wr_ptr_q] <= lanes_i.byte_data[l];
  end

  no_overflow: assert property (
    @( posedge byte_clk_i ) disable iff ( rst_i || pkt_done_i )
    wr && full[l] |-> pop
  );
end

always_ff @( posedge byte_clk_i )
begin
  if( rst_i )
  begin
    word_valid_q <= 1'b0;
    rearm_q      <= 1'b0;
    flush_q      <= 1'b0;
  end
  else
  begin
    word_valid_q <= pop && !pkt_done_i;
    rearm_q      <= pkt_done_i;
    flush_q      <= pkt_done_i; // mapper drops any partial word.
  end
end

always_ff @( posedge byte_clk_i )
begin
  if( pop )
    for( int l = 0; l < DATA_LANES; l++ )
      lane_word_q[l] <= head[l];
end

assign lanes_i.rearm = rearm_q;
assign lane_word_o   = lane_word_q;
assign word_valid_o  = word_valid_q;
assign flush_o       = flush_q;

endmodule

// ==== source/dphy_32b_map.sv ====
`timescale 1ns/1ns
`include "dphy_consts.svh"

module dphy_32b_map #(
  parameter int DATA_LANES = `DPHY_DATA_LANES
)(
  input                                             byte_clk_i,
  input                                             rst_i,
  input dphy_lane_pkg::lane_byte_t [DATA_LANES-1:0] lane_word_i,
  input                                             word_valid_i,
  input                                             flush_i,
  output dphy_word_pkg::word_t                      data_o,
  output                                            valid_o
);

// byte index at which the incoming lane word completes the 32 bits.
localparam dphy_word_pkg::byte_idx_t LAST_FILL = dphy_word_pkg::byte_idx_t'( 4 - DATA_LANES );

dphy_word_pkg::byte_idx_t        fill_q;
dphy_lane_pkg::lane_byte_t [3:0] part_q;
dphy_lane_pkg::lane_byte_t [3:0] next_part;
logic                            complete;
dphy_word_pkg::word_t            data_q;
logic                            valid_q;

always_comb
begin
  next_part = part_q;
  for( int l = 0; l < DATA_LANES; l++ )
    next_part[fill_q + dphy_word_pkg::byte_idx_t'( l )] = lane_word_i[l];
end

assign complete = word_valid_i && ( fill_q == LAST_FILL );

always_ff @( posedge byte_clk_i )
begin
  if( rst_i || flush_i )
  begin
    fill_q  <= '0;
    valid_q <= 1'b0;
  end
  else
  begin
    valid_q <= complete;
    if( word_valid_i )
      fill_q <= fill_q + dphy_word_pkg::byte_idx_t'( DATA_LANES ); // wraps to 0 on a full word.
  end
end

always_ff @( posedge byte_clk_i )
begin
  if( word_valid_i )
    part_q <= next_part;
  if( complete )
    data_q <= dphy_word_pkg::word_t'( next_part );
end

assign data_o  = data_q;
assign valid_o = valid_q;

legal_lanes: assert property (
  @( posedge byte_clk_i ) DATA_LANES inside { 1, 2, 4 }
);

endmodule

// ==== source/dphy_slave.sv ====
`timescale 1ns/1ns
`include "dphy_consts.svh"

module dphy_slave #(
  parameter int DATA_LANES = `DPHY_DATA_LANES
)(
  input                        byte_clk_i,
  input                        rst_i,
  input                        enable_i,
  input                        pkt_done_i,
  input  [DATA_LANES-1:0][7:0] lane_byte_i,
  output [31:0]                data_o,
  output                       valid_o
);

dphy_lane_pkg::lane_byte_t [DATA_LANES-1:0] lane_word;
logic                                       word_valid;
logic                                       flush;

// aligned bytes and lock status of all lanes, with the re-arm pulse back.
dphy_lane_if #(
  .DATA_LANES ( DATA_LANES )
) lanes ();

for( genvar i = 0; i < DATA_LANES; i++ )
begin : byte_align
  dphy_byte_align #(
    .LANE             ( i              )
  ) byte_aligner (
    .byte_clk_i       ( byte_clk_i     ),
    .rst_i            ( rst_i          ),
    .enable_i         ( enable_i       ),
    .unaligned_byte_i ( lane_byte_i[i] ),
    .lane_o           ( lanes.align    )
  );
end

dphy_word_align #(
  .DATA_LANES   ( DATA_LANES   )
) word_aligner (
  .byte_clk_i   ( byte_clk_i   ),
  .rst_i        ( rst_i        ),
  .pkt_done_i   ( pkt_done_i   ),
  .lanes_i      ( lanes.deskew ),
  .lane_word_o  ( lane_word    ),
  .word_valid_o ( word_valid   ),
  .flush_o      ( flush        )
);

dphy_32b_map #(
  .DATA_LANES   ( DATA_LANES )
) mapper (
  .byte_clk_i   ( byte_clk_i ),
  .rst_i        ( rst_i      ),
  .lane_word_i  ( lane_word  ),
  .word_valid_i ( word_valid ),
  .flush_i      ( flush      ),
  .data_o       ( data_o     ),
  .valid_o      ( valid_o    )
);

endmodule

// ==== tb/tb_dphy_slave.sv ====
`timescale 1ns/1ns
`include "dphy_consts.svh"

module tb_dphy_slave;

localparam int         LANES           = `DPHY_DATA_LANES;
localparam int         CLK_PERIOD      = 4;
localparam int         RST_CYCLES      = 16;
localparam int         IDLE_BYTES      = 4;
localparam int         MAX_PAYLOAD     = 64;
localparam int         NUM_PKTS        = 9;
localparam int         MAX_TOTAL_WORDS = NUM_PKTS * MAX_PAYLOAD / 4;
// worst packet is one lane at full payload, plus latency, flush and idle gap.
localparam int         PKT_CYCLES      = 2 * IDLE_BYTES + 4 + MAX_PAYLOAD + 16
                                         + `DPHY_FLUSH_CYCLES;
localparam int         WATCHDOG_NS     = 2 * CLK_PERIOD * ( RST_CYCLES + NUM_PKTS * PKT_CYCLES );
localparam logic [7:0] SYNC            = `DPHY_SYNC_BYTE;

logic                   byte_clk = 1'b0;
logic                   rst;
logic                   enable;
logic                   pkt_done;
logic [LANES-1:0][7:0]  lane_byte;
logic [31:0]            data;
logic                   valid;

logic [7:0]             payload   [MAX_PAYLOAD];
int                     payload_len;
int                     lane_off  [LANES];
int                     lane_skew [LANES];
logic [31:0]            exp_words [MAX_TOTAL_WORDS];
int                     exp_total;
int                     got;
logic                   ignore_valid;

always #( CLK_PERIOD / 2 ) byte_clk = ~byte_clk;

dphy_slave #(
  .DATA_LANES  ( LANES     )
) dut0 (
  .byte_clk_i  ( byte_clk  ),
  .rst_i       ( rst       ),
  .enable_i    ( enable    ),
  .pkt_done_i  ( pkt_done  ),
  .lane_byte_i ( lane_byte ),
  .data_o      ( data      ),
  .valid_o     ( valid     )
);

// packs the payload in arrival order so that the first byte lands in bits 7:0.
function automatic logic [31:0] expected_word( input int w );
  logic [31:0] word;
  word = '0;
  for( int b = 0; b < 4; b++ )
    word[8*b +: 8] = payload[4*w + b];
  return word;
endfunction

// byte n of a lane holds idle zeros, the sync byte, the lane's share of the payload and zeros.
function automatic logic [7:0] stream_byte( input int lane, input int n );
  logic [7:0] b;
  logic [7:0] src;
  int         lead;
  int         pos;
  int         per_lane;
  b        = '0;
  per_lane = payload_len / LANES;
  lead     = 8 * ( IDLE_BYTES + lane_skew[lane] ) + lane_off[lane];
  for( int j = 0; j < 8; j++ )
  begin
    pos = 8 * n + j - lead;
    if( pos >= 0 && pos < 8 )
      b[j] = SYNC[pos];
    else if( pos >= 8 && pos < 8 * ( per_lane + 1 ) )
    begin
      src  = payload[( ( pos - 8 ) / 8 ) * LANES + lane]; // round-robin dealing.
      b[j] = src[( pos - 8 ) % 8];
    end
  end
  return b;
endfunction

task automatic check_equal( input logic [31:0] actual, input logic [31:0] expected,
                            input string what );
  if( actual !== expected )
  begin
    $display( "Error at %0t ns: %s is %08h, expected %08h", $time, what, actual, expected );
    $display( "Test failures found" );
    $fatal( 1, "stopping at the first mismatch" );
  end
endtask

// sends one packet; with en low the receiver must stay silent.
task automatic run_packet( input int len, input int max_off, input int max_skew,
                           input logic en );
  int                    n_bytes;
  logic [LANES-1:0][7:0] lane_bytes;
  payload_len = len;
  for( int i = 0; i < len; i++ )
    payload[i] = 8'( $urandom );
  for( int l = 0; l < LANES; l++ )
  begin
    lane_off[l]  = int'( $urandom_range( max_off, 0 ) );
    lane_skew[l] = int'( $urandom_range( max_skew, 0 ) );
  end
  if( en )
  begin
    for( int w = 0; w < len / 4; w++ )
      exp_words[exp_total + w] = expected_word( w );
    exp_total = exp_total + len / 4;
  end
  n_bytes = IDLE_BYTES + 4 + len / LANES; // covers worst skew and offset.
  @( posedge byte_clk );
  enable <= en;
  for( int n = 0; n < n_bytes; n++ )
  begin
    @( posedge byte_clk );
    for( int l = 0; l < LANES; l++ )
      lane_bytes[l] = stream_byte( l, n );
    lane_byte <= lane_bytes;
  end
  @( posedge byte_clk );
  lane_byte <= '0;
  if( en )
  begin
    while( got < exp_total )
      @( posedge byte_clk );
    // trailing zero bytes may form words until the flush lands.
    pkt_done     <= 1'b1;
    ignore_valid = 1'b1;
    @( posedge byte_clk );
    pkt_done <= 1'b0;
    repeat( `DPHY_FLUSH_CYCLES - 1 )
      @( posedge byte_clk );
    ignore_valid = 1'b0;
  end
  repeat( IDLE_BYTES )
    @( posedge byte_clk );
  enable <= 1'b1;
endtask

// outputs are sampled on the falling edge half a cycle after they change.
always @( negedge byte_clk )
begin
  if( !rst && valid === 1'b1 && !ignore_valid )
  begin
    if( got >= exp_total )
    begin
      $display( "Unexpected output word %08h at %0t ns while no word was due", data, $time );
      $display( "Test failures found" );
      $fatal( 1, "stopping on an unexpected word" );
    end
    else
    begin
      check_equal( data, exp_words[got], "output word" );
      got = got + 1;
    end
  end
end

initial
begin
  #( WATCHDOG_NS );
  $display( "Timeout: the receiver did not deliver every expected word in time" );
  $display( "Test failures found" );
  $fatal( 1, "watchdog expired" );
end

initial
begin
  void'( $urandom( 32'h6bd1 ) );
  rst          = 1'b1;
  enable       = 1'b0;
  pkt_done     = 1'b0;
  lane_byte    = '0;
  ignore_valid = 1'b0;
  exp_total    = 0;
  got          = 0;
  repeat( RST_CYCLES )
    @( posedge byte_clk );
  rst    <= 1'b0;
  enable <= 1'b1;

  run_packet( 32, 0, 0, 1'b1 ); // aligned lanes.
  run_packet( 32, 7, 0, 1'b1 ); // bit offsets only.
  run_packet( 48, 7, 2, 1'b1 ); // offsets and lane skew.

  // back to back packets of different lengths.
  for( int p = 0; p < 4; p++ )
    run_packet( 16 * ( p + 1 ), 7, 2, 1'b1 );

  run_packet( 24, 7, 2, 1'b0 );
  run_packet( 32, 7, 2, 1'b1 ); // received again after enable returns.

  $display( "All tests passed!" );
  $finish;
end

endmodule

// ==== src.f ====
+incdir+source
source/dphy_lane_pkg.sv
source/dphy_word_pkg.sv
source/dphy_lane_if.sv
source/dphy_byte_align.sv
source/dphy_word_align.sv
source/dphy_32b_map.sv
source/dphy_slave.sv
tb/tb_dphy_slave.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dphy_slave
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check it"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(wildcard source/*.sv source/*.svh tb/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
